//--- logic/rv_isa_pkg.sv
// rv64i widths, instruction format union, opcode/funct3 codes, alu op codes
`default_nettype none

package rv_isa_pkg;

  localparam int xlen        = 64; // gpr and pc width
  localparam int inst_wd     = 32;
  localparam int gpr_addr_wd = 5;

  // one struct per base format, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // same 32 bits, six readings
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  localparam logic [6:0] opc_op        = 7'b0110011;
  localparam logic [6:0] opc_op_imm    = 7'b0010011;
  localparam logic [6:0] opc_op_32     = 7'b0111011;
  localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
  localparam logic [6:0] opc_lui       = 7'b0110111;
  localparam logic [6:0] opc_auipc     = 7'b0010111;
  localparam logic [6:0] opc_load      = 7'b0000011;
  localparam logic [6:0] opc_store     = 7'b0100011;
  localparam logic [6:0] opc_branch    = 7'b1100011;
  localparam logic [6:0] opc_jal       = 7'b1101111;
  localparam logic [6:0] opc_jalr      = 7'b1100111;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [4:0] alu_add  = 5'd0;
  localparam logic [4:0] alu_sub  = 5'd1;
  localparam logic [4:0] alu_sll  = 5'd2;
  localparam logic [4:0] alu_slt  = 5'd3;
  localparam logic [4:0] alu_sltu = 5'd4;
  localparam logic [4:0] alu_xor  = 5'd5;
  localparam logic [4:0] alu_srl  = 5'd6;
  localparam logic [4:0] alu_sra  = 5'd7;
  localparam logic [4:0] alu_or   = 5'd8;
  localparam logic [4:0] alu_and  = 5'd9;
  localparam logic [4:0] alu_lui  = 5'd10; // passes operand 2 through

endpackage

`default_nettype wire

//--- logic/pipe_bus_pkg.sv
// fetch, control, execute, redirect and write-back bus structs, alu operand 2 selects
`default_nettype none

package pipe_bus_pkg;

  import rv_isa_pkg::*;

  // alu operand 2 select
  localparam logic [1:0] src2_rs2  = 2'd0;
  localparam logic [1:0] src2_imm  = 2'd1;
  localparam logic [1:0] src2_four = 2'd2; // link address pc + 4

  // fetch to decode
  typedef struct packed {
    logic [xlen-1:0]    pc;
    logic [inst_wd-1:0] inst;
  } fs_to_ds_t;

  typedef struct packed {
    logic       alu_src1_pc;  // pc instead of rs1
    logic [1:0] alu_src2_sel;
    logic       word_op;      // 32-bit result, sign extended
    logic [4:0] alu_op;
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;       // funct3 of the access
    logic       invalid;
  } ctrl_t;

  // decode to execute
  typedef struct packed {
    logic [xlen-1:0]        rs1_data;
    logic [xlen-1:0]        rs2_data;
    logic [xlen-1:0]        imm;
    logic [xlen-1:0]        pc;
    logic [gpr_addr_wd-1:0] rd;
    ctrl_t                  ctrl;
  } ds_to_es_t;

  // decode to fetch
  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } br_t;

  // write-back to register file
  typedef struct packed {
    logic                   wen;
    logic [gpr_addr_wd-1:0] waddr;
    logic [xlen-1:0]        wdata;
  } wb_t;

endpackage

`default_nettype wire

//--- logic/inst_decoder.sv
// inst_decoder: rv64i register indices, immediates, source-use flags and control fields
`timescale 1ns/1ps
`default_nettype none

module inst_decoder import rv_isa_pkg::*, pipe_bus_pkg::*; (
  input  wire inst_u                   i_inst,
  output logic [gpr_addr_wd-1:0] o_rs1,
  output logic [gpr_addr_wd-1:0] o_rs2,
  output logic [gpr_addr_wd-1:0] o_rd,
  output logic                   o_uses_rs1,
  output logic                   o_uses_rs2,
  output logic [xlen-1:0]        o_imm,
  output ctrl_t                  o_ctrl,
  output logic                   o_is_branch,
  output logic                   o_is_jal,
  output logic                   o_is_jalr
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic            bad;

  // shared by op, op-imm and their 32-bit forms
  function automatic logic [4:0] alu_of(input logic [2:0] f3, input logic alt);
    logic [4:0] op;
    case (f3)
      3'b000:  op = alt ? alu_sub : alu_add;
      3'b001:  op = alu_sll;
      3'b010:  op = alu_slt;
      3'b011:  op = alu_sltu;
      3'b100:  op = alu_xor;
      3'b101:  op = alt ? alu_sra : alu_srl;
      3'b110:  op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign opcode = i_inst.r.opcode;
  assign funct3 = i_inst.r.funct3;
  assign funct7 = i_inst.r.funct7; // imm[11:5] for shift immediates

  assign imm_i = {{(xlen-12){i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
  assign imm_s = {{(xlen-12){i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
  assign imm_b = {{(xlen-12){i_inst.b.imm_12}}, i_inst.b.imm_11, i_inst.b.imm_10_5,
                  i_inst.b.imm_4_1, 1'b0};
  assign imm_u = {{(xlen-32){i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'b0};
  assign imm_j = {{(xlen-20){i_inst.j.imm_20}}, i_inst.j.imm_19_12, i_inst.j.imm_11,
                  i_inst.j.imm_10_1, 1'b0};

  always_comb begin
    o_ctrl      = '0;
    o_uses_rs1  = 1'b0;
    o_uses_rs2  = 1'b0;
    o_imm       = '0;
    o_is_branch = 1'b0;
    o_is_jal    = 1'b0;
    o_is_jalr   = 1'b0;
    bad         = 1'b0;
    o_ctrl.alu_src2_sel = src2_rs2;
    o_ctrl.alu_op       = alu_add;
    case (opcode)
      opc_op: begin
        o_uses_rs1     = 1'b1;
        o_uses_rs2     = 1'b1;
        o_ctrl.gpr_wen = 1'b1;
        o_ctrl.alu_op  = alu_of(funct3, funct7[5]);
        // only sub and sra use the alternate funct7
        bad = !(funct7 == 7'b0 ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      opc_op_imm: begin
        o_uses_rs1          = 1'b1;
        o_imm               = imm_i;
        o_ctrl.alu_src2_sel = src2_imm;
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.alu_op       = alu_of(funct3, funct3 == 3'b101 && funct7[5]);
        if (funct3 == 3'b001)
          bad = funct7[6:1] != 6'b0; // 6-bit shamt
        else if (funct3 == 3'b101)
          bad = funct7[6:1] != 6'b0 && funct7[6:1] != 6'b010000;
      end
      opc_op_32: begin
        o_uses_rs1     = 1'b1;
        o_uses_rs2     = 1'b1;
        o_ctrl.word_op = 1'b1;
        o_ctrl.gpr_wen = 1'b1;
        o_ctrl.alu_op  = alu_of(funct3, funct7[5]);
        bad = !((funct7 == 7'b0 &&
                 (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101)) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      opc_op_imm_32: begin
        o_uses_rs1          = 1'b1;
        o_imm               = imm_i;
        o_ctrl.alu_src2_sel = src2_imm;
        o_ctrl.word_op      = 1'b1;
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.alu_op       = alu_of(funct3, funct3 == 3'b101 && funct7[5]);
        case (funct3)
          3'b000:  bad = 1'b0;
          3'b001:  bad = funct7 != 7'b0;
          3'b101:  bad = funct7 != 7'b0 && funct7 != 7'b0100000;
          default: bad = 1'b1;
        endcase
      end
      opc_lui: begin
        o_imm               = imm_u;
        o_ctrl.alu_src2_sel = src2_imm;
        o_ctrl.alu_op       = alu_lui;
        o_ctrl.gpr_wen      = 1'b1;
      end
      opc_auipc: begin
        o_imm               = imm_u;
        o_ctrl.alu_src1_pc  = 1'b1;
        o_ctrl.alu_src2_sel = src2_imm;
        o_ctrl.gpr_wen      = 1'b1;
      end
      opc_load: begin
        o_uses_rs1          = 1'b1;
        o_imm               = imm_i;
        o_ctrl.alu_src2_sel = src2_imm; // address = rs1 + imm
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.mem_ren      = 1'b1;
        o_ctrl.mem_op       = funct3;
        bad = funct3 == 3'b111;
      end
      opc_store: begin
        o_uses_rs1          = 1'b1;
        o_uses_rs2          = 1'b1;
        o_imm               = imm_s;
        o_ctrl.alu_src2_sel = src2_imm;
        o_ctrl.mem_wen      = 1'b1;
        o_ctrl.mem_op       = funct3;
        bad = funct3[2];
      end
      opc_branch: begin
        o_uses_rs1  = 1'b1;
        o_uses_rs2  = 1'b1;
        o_imm       = imm_b;
        o_is_branch = 1'b1;
        bad = funct3[2:1] == 2'b01;
      end
      opc_jal: begin
        o_imm               = imm_j;
        o_ctrl.alu_src1_pc  = 1'b1;
        o_ctrl.alu_src2_sel = src2_four;
        o_ctrl.gpr_wen      = 1'b1;
        o_is_jal            = 1'b1;
      end
      opc_jalr: begin
        o_uses_rs1          = 1'b1;
        o_imm               = imm_i;
        o_ctrl.alu_src1_pc  = 1'b1;
        o_ctrl.alu_src2_sel = src2_four;
        o_ctrl.gpr_wen      = 1'b1;
        o_is_jalr           = 1'b1;
        bad = funct3 != 3'b000;
      end
      default: bad = 1'b1;
    endcase
    // an invalid word must not write anything or redirect fetch
    if (bad) begin
      o_ctrl.invalid = 1'b1;
      o_ctrl.gpr_wen = 1'b0;
      o_ctrl.mem_ren = 1'b0;
      o_ctrl.mem_wen = 1'b0;
      o_is_branch    = 1'b0;
      o_is_jal       = 1'b0;
      o_is_jalr      = 1'b0;
    end
  end

  assign o_rs1 = i_inst.r.rs1;
  assign o_rs2 = i_inst.r.rs2;
  assign o_rd  = o_ctrl.gpr_wen ? i_inst.r.rd : '0; // zero when nothing is written back

endmodule

`default_nettype wire

//--- logic/gpr_file.sv
// gpr_file: 31 x 64-bit general registers, two async reads, one write port, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module gpr_file import rv_isa_pkg::*, pipe_bus_pkg::*; (
  input  wire                         i_clk,
  input  wire [gpr_addr_wd-1:0] i_raddr1,
  input  wire [gpr_addr_wd-1:0] i_raddr2,
  input  wire wb_t                    i_wb,
  output logic [xlen-1:0]       o_rdata1,
  output logic [xlen-1:0]       o_rdata2
);

  logic [xlen-1:0] regs [1:31]; // no storage for x0

  always_ff @(posedge i_clk) begin
    if (i_wb.wen && i_wb.waddr != '0) begin
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  // read sees the old value in the write cycle
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
// branch_unit: branch compares, jal/jalr take, redirect target
`timescale 1ns/1ps
`default_nettype none

module branch_unit import rv_isa_pkg::*; (
  input  wire [xlen-1:0] i_rs1_data,
  input  wire [xlen-1:0] i_rs2_data,
  input  wire [xlen-1:0] i_pc,
  input  wire [xlen-1:0] i_imm,
  input  wire [2:0]      i_funct3,
  input  wire            i_is_branch,
  input  wire            i_is_jal,
  input  wire            i_is_jalr,
  output logic           o_taken,
  output logic [xlen-1:0] o_target
);

  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            cond;
  logic [xlen-1:0] jalr_sum;

  assign eq   = i_rs1_data == i_rs2_data;
  assign lt_s = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign lt_u = i_rs1_data < i_rs2_data;

  always_comb begin
    case (i_funct3)
      f3_beq:  cond = eq;
      f3_bne:  cond = !eq;
      f3_blt:  cond = lt_s;
      f3_bge:  cond = !lt_s;
      f3_bltu: cond = lt_u;
      f3_bgeu: cond = !lt_u;
      default: cond = 1'b0; // 010/011 are not branches
    endcase
  end

  assign o_taken  = i_is_jal || i_is_jalr || (i_is_branch && cond);
  assign jalr_sum = i_rs1_data + i_imm;
  assign o_target = i_is_jalr ? {jalr_sum[xlen-1:1], 1'b0} : i_pc + i_imm;

endmodule

`default_nettype wire

//--- logic/id_stage.sv
// id_stage: decode pipeline register, raw interlock, flow control, execute and redirect buses
`timescale 1ns/1ps
`default_nettype none

module id_stage import rv_isa_pkg::*, pipe_bus_pkg::*; (
  input  wire                         i_clk,
  input  wire                         i_rst,
  // fetch side
  input  wire                         i_fs_valid,
  input  wire fs_to_ds_t              i_fs,
  output logic                        o_ds_allowin,
  // execute side
  input  wire                         i_es_allowin,
  output logic                        o_ds_to_es_valid,
  output ds_to_es_t                   o_ds_to_es,
  // redirect to fetch
  output br_t                         o_br,
  // write-back port
  input  wire wb_t                    i_wb,
  // destinations still in flight
  input  wire [gpr_addr_wd-1:0] i_es_rd,
  input  wire [gpr_addr_wd-1:0] i_ms_rd,
  input  wire [gpr_addr_wd-1:0] i_ws_rd
);

  logic                   ds_valid;
  fs_to_ds_t              ds_r;      // payload, no reset
  inst_u                  ds_inst;
  logic                   ready_go;
  logic [gpr_addr_wd-1:0] rs1;
  logic [gpr_addr_wd-1:0] rs2;
  logic [gpr_addr_wd-1:0] rd;
  logic                   uses_rs1;
  logic                   uses_rs2;
  logic [xlen-1:0]        imm;
  ctrl_t                  ctrl;
  logic                   is_branch;
  logic                   is_jal;
  logic                   is_jalr;
  logic [xlen-1:0]        rs1_data;
  logic [xlen-1:0]        rs2_data;
  logic                   bu_taken;
  logic [xlen-1:0]        bu_target;

  // x0 never blocks, nor does a field the instruction does not read
  function automatic logic raw_hit(input logic [gpr_addr_wd-1:0] dst);
    return dst != '0 && ((uses_rs1 && dst == rs1) || (uses_rs2 && dst == rs2));
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_valid && o_ds_allowin) begin
      ds_r <= i_fs;
    end
  end

  assign ds_inst = ds_r.inst;

  always_comb begin
    ready_go = !(raw_hit(i_es_rd) || raw_hit(i_ms_rd) || raw_hit(i_ws_rd));
  end

  assign o_ds_allowin     = !ds_valid || (ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ready_go;

  inst_decoder u_dec (
    .i_inst      (ds_inst),
    .o_rs1       (rs1),
    .o_rs2       (rs2),
    .o_rd        (rd),
    .o_uses_rs1  (uses_rs1),
    .o_uses_rs2  (uses_rs2),
    .o_imm       (imm),
    .o_ctrl      (ctrl),
    .o_is_branch (is_branch),
    .o_is_jal    (is_jal),
    .o_is_jalr   (is_jalr)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wb     (i_wb),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data)
  );

  branch_unit u_bru (
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_pc        (ds_r.pc),
    .i_imm       (imm),
    .i_funct3    (ds_inst.b.funct3),
    .i_is_branch (is_branch),
    .i_is_jal    (is_jal),
    .i_is_jalr   (is_jalr),
    .o_taken     (bu_taken),
    .o_target    (bu_target)
  );

  assign o_ds_to_es.rs1_data = rs1_data;
  assign o_ds_to_es.rs2_data = rs2_data;
  assign o_ds_to_es.imm      = imm;
  assign o_ds_to_es.pc       = ds_r.pc;
  assign o_ds_to_es.rd       = rd;
  assign o_ds_to_es.ctrl     = ctrl;

  // redirect only once operands are safe to use
  assign o_br.taken  = bu_taken && o_ds_to_es_valid;
  assign o_br.target = bu_target;

endmodule

`default_nettype wire

//--- tb/id_stage_assert.sv
// id_stage_assert: shadow register file, expected decode rules and bound port checks
`timescale 1ns/1ps
`default_nettype none

module id_stage_assert import rv_isa_pkg::*, pipe_bus_pkg::*; (
  input wire            i_clk,
  input wire            i_rst,
  input wire            i_fs_valid,
  input wire fs_to_ds_t i_fs,
  input wire            o_ds_allowin,
  input wire            i_es_allowin,
  input wire            o_ds_to_es_valid,
  input wire ds_to_es_t o_ds_to_es,
  input wire br_t       o_br,
  input wire wb_t       i_wb,
  input wire [4:0]      i_es_rd,
  input wire [4:0]      i_ms_rd,
  input wire [4:0]      i_ws_rd
);

  localparam int hold_wd = 2 * xlen + gpr_addr_wd + $bits(ctrl_t);

  int                 fail_cnt = 0;
  logic [xlen-1:0]    shadow [1:31];
  logic               valid_q;
  fs_to_ds_t          item_q;
  logic [hold_wd-1:0] hold_now; // execute bus without register data
  logic [hold_wd-1:0] hold_q;
  logic [31:0]        w;
  logic [2:0]         f3;
  logic [6:0]         f7;
  logic               legal;
  logic               use1;
  logic               use2;
  logic               stall_x;
  logic               cond;
  logic               taken_x;
  logic               ctrl_ok;
  logic [xlen-1:0]    a;
  logic [xlen-1:0]    b;
  logic [xlen-1:0]    imm_x;
  logic [xlen-1:0]    tgt_x;
  logic [4:0]         rd_x;
  ctrl_t              ctrl_x;

  function automatic logic hit(input logic [4:0] dst, input logic [31:0] inst,
                               input logic u1, input logic u2);
    return dst != 5'd0 && ((u1 && dst == inst[19:15]) || (u2 && dst == inst[24:20]));
  endfunction

  // base alu table, alt selects sub or sra
  function automatic logic [4:0] alu_code(input logic [2:0] fn, input logic alt);
    case (fn)
      3'd0:    return alt ? alu_sub : alu_add;
      3'd1:    return alu_sll;
      3'd2:    return alu_slt;
      3'd3:    return alu_sltu;
      3'd4:    return alu_xor;
      3'd5:    return alt ? alu_sra : alu_srl;
      3'd6:    return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign hold_now = {o_ds_to_es.imm, o_ds_to_es.pc, o_ds_to_es.rd, o_ds_to_es.ctrl};

  always_ff @(posedge i_clk) begin
    if (i_wb.wen && i_wb.waddr != 5'd0) begin
      shadow[i_wb.waddr] <= i_wb.wdata;
    end
    if (i_rst) begin
      valid_q <= 1'b0;
    end else if (o_ds_allowin) begin
      valid_q <= i_fs_valid;
    end
    if (i_fs_valid && o_ds_allowin) begin
      item_q <= i_fs;
    end
    hold_q <= hold_now;
  end

  assign w  = item_q.inst;
  assign f3 = w[14:12];
  assign f7 = w[31:25];
  assign a  = (w[19:15] == 5'd0) ? '0 : shadow[w[19:15]];
  assign b  = (w[24:20] == 5'd0) ? '0 : shadow[w[24:20]];

  always_comb begin
    ctrl_x = '0;
    imm_x  = '0;
    legal  = 1'b1;
    use1   = 1'b0;
    use2   = 1'b0;
    case (w[6:0])
      opc_op, opc_op_32: begin
        use1 = 1'b1;
        use2 = 1'b1;
        ctrl_x.gpr_wen = 1'b1;
        ctrl_x.word_op = w[6:0] == opc_op_32;
        ctrl_x.alu_op  = alu_code(f3, w[30]);
        if (w[6:0] == opc_op)
          legal = f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else
          legal = (f7 == 7'h00 && f3 inside {3'd0, 3'd1, 3'd5}) ||
                  (f7 == 7'h20 && f3 inside {3'd0, 3'd5});
      end
      opc_op_imm, opc_op_imm_32: begin
        use1  = 1'b1;
        imm_x = {{52{w[31]}}, w[31:20]};
        ctrl_x.alu_src2_sel = src2_imm;
        ctrl_x.gpr_wen      = 1'b1;
        ctrl_x.word_op      = w[6:0] == opc_op_imm_32;
        ctrl_x.alu_op       = alu_code(f3, f3 == 3'd5 && w[30]);
        if (w[6:0] == opc_op_imm)   // rv64 shamt is 6 bits
          legal = f3 == 3'd1 ? w[31:26] == 6'h00 :
                  f3 == 3'd5 ? (w[31:26] == 6'h00 || w[31:26] == 6'h10) : 1'b1;
        else
          legal = f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'h00) ||
                  (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
      end
      opc_lui, opc_auipc: begin
        imm_x = {{32{w[31]}}, w[31:12], 12'h000};
        ctrl_x.alu_src2_sel = src2_imm;
        ctrl_x.gpr_wen      = 1'b1;
        ctrl_x.alu_src1_pc  = w[6:0] == opc_auipc;
        ctrl_x.alu_op       = (w[6:0] == opc_lui) ? alu_lui : alu_add;
      end
      opc_load: begin
        use1  = 1'b1;
        imm_x = {{52{w[31]}}, w[31:20]};
        ctrl_x.alu_src2_sel = src2_imm;
        ctrl_x.gpr_wen      = 1'b1;
        ctrl_x.mem_ren      = 1'b1;
        ctrl_x.mem_op       = f3;
        legal = f3 != 3'd7;
      end
      opc_store: begin
        use1  = 1'b1;
        use2  = 1'b1;
        imm_x = {{52{w[31]}}, w[31:25], w[11:7]};
        ctrl_x.alu_src2_sel = src2_imm;
        ctrl_x.mem_wen      = 1'b1;
        ctrl_x.mem_op       = f3;
        legal = !f3[2];
      end
      opc_branch: begin
        use1  = 1'b1;
        use2  = 1'b1;
        imm_x = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        legal = !(f3 == 3'd2 || f3 == 3'd3);
      end
      opc_jal, opc_jalr: begin
        use1  = w[6:0] == opc_jalr;
        imm_x = (w[6:0] == opc_jal) ? {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0}
                                    : {{52{w[31]}}, w[31:20]};
        ctrl_x.alu_src1_pc  = 1'b1;
        ctrl_x.alu_src2_sel = src2_four;
        ctrl_x.gpr_wen      = 1'b1;
        legal = w[6:0] == opc_jal || f3 == 3'd0;
      end
      default: legal = 1'b0;
    endcase
    ctrl_x.invalid = !legal;
    rd_x = (legal && ctrl_x.gpr_wen) ? w[11:7] : 5'd0;
    ctrl_ok = legal ? o_ds_to_es.ctrl == ctrl_x
                    : (o_ds_to_es.ctrl.invalid && !o_ds_to_es.ctrl.gpr_wen &&
                       !o_ds_to_es.ctrl.mem_ren && !o_ds_to_es.ctrl.mem_wen);
    case (f3)
      3'd0:    cond = a == b;
      3'd1:    cond = a != b;
      3'd4:    cond = $signed(a) < $signed(b);
      3'd5:    cond = $signed(a) >= $signed(b);
      3'd6:    cond = a < b;
      3'd7:    cond = a >= b;
      default: cond = 1'b0;
    endcase
    stall_x = hit(i_es_rd, w, use1, use2) || hit(i_ms_rd, w, use1, use2) ||
              hit(i_ws_rd, w, use1, use2);
    taken_x = valid_q && !stall_x && legal && (w[6:0] == opc_jal || w[6:0] == opc_jalr ||
              (w[6:0] == opc_branch && cond));
    tgt_x = (w[6:0] == opc_jalr) ? ((a + imm_x) & ~64'd1) : item_q.pc + imm_x;
  end

  a_reset: assert property (@(posedge i_clk)
    i_rst |=> (!o_ds_to_es_valid && !o_br.taken && o_ds_allowin))
    else begin
      fail_cnt++;
      $error("CHECK FAILED reset expected %b actual %b", 3'b001,
             {o_ds_to_es_valid, o_br.taken, o_ds_allowin});
    end

  a_valid: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid == (valid_q && !stall_x))
    else begin
      fail_cnt++;
      $error("CHECK FAILED interlock expected %b actual %b", valid_q && !stall_x,
             o_ds_to_es_valid);
    end

  a_allowin: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_allowin == (!valid_q || (!stall_x && i_es_allowin)))
    else begin
      fail_cnt++;
      $error("CHECK FAILED allowin expected %b actual %b",
             !valid_q || (!stall_x && i_es_allowin), o_ds_allowin);
    end

  a_rs1: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid |-> o_ds_to_es.rs1_data == a)
    else begin
      fail_cnt++;
      $error("CHECK FAILED rs1_data expected %h actual %h", a, o_ds_to_es.rs1_data);
    end

  a_rs2: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid |-> o_ds_to_es.rs2_data == b)
    else begin
      fail_cnt++;
      $error("CHECK FAILED rs2_data expected %h actual %h", b, o_ds_to_es.rs2_data);
    end

  // register data may change through write-back, the rest must hold
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid && !i_es_allowin |=> hold_now == hold_q)
    else begin
      fail_cnt++;
      $error("CHECK FAILED hold expected %h actual %h", hold_q, hold_now);
    end

  a_ctrl: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid |-> ctrl_ok)
    else begin
      fail_cnt++;
      $error("CHECK FAILED ctrl expected %h actual %h", ctrl_x, o_ds_to_es.ctrl);
    end

  a_imm: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid && legal |-> o_ds_to_es.imm == imm_x)
    else begin
      fail_cnt++;
      $error("CHECK FAILED imm expected %h actual %h", imm_x, o_ds_to_es.imm);
    end

  a_rd: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ds_to_es_valid |-> o_ds_to_es.rd == rd_x && o_ds_to_es.pc == item_q.pc)
    else begin
      fail_cnt++;
      $error("CHECK FAILED rd_pc expected %h actual %h", {rd_x, item_q.pc},
             {o_ds_to_es.rd, o_ds_to_es.pc});
    end

  a_taken: assert property (@(posedge i_clk) disable iff (i_rst)
    o_br.taken == taken_x)
    else begin
      fail_cnt++;
      $error("CHECK FAILED br_taken expected %b actual %b", taken_x, o_br.taken);
    end

  a_target: assert property (@(posedge i_clk) disable iff (i_rst)
    o_br.taken |-> o_br.target == tgt_x)
    else begin
      fail_cnt++;
      $error("CHECK FAILED br_target expected %h actual %h", tgt_x, o_br.target);
    end

endmodule

bind id_stage id_stage_assert u_check (.*);

`default_nettype wire

//--- tb/id_stage_tb.sv
// id_stage_tb: clock, reset, register preload, directed and random decode stimulus
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb import rv_isa_pkg::*, pipe_bus_pkg::*;;

  localparam int max_wait = 200;

  logic            i_clk;
  logic            i_rst;
  logic            i_fs_valid;
  fs_to_ds_t       i_fs;
  logic            i_es_allowin;
  wb_t             i_wb;
  logic [4:0]      i_es_rd;
  logic [4:0]      i_ms_rd;
  logic [4:0]      i_ws_rd;
  logic            o_ds_allowin;
  logic            o_ds_to_es_valid;
  ds_to_es_t       o_ds_to_es;
  br_t             o_br;
  logic            rnd_on;
  int              timeouts;
  logic [xlen-1:0] pc;
  logic [31:0]     dir [$];
  logic [6:0]      kept [0:10];

  id_stage dut_i (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fs_valid       (i_fs_valid),
    .i_fs             (i_fs),
    .o_ds_allowin     (o_ds_allowin),
    .i_es_allowin     (i_es_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es       (o_ds_to_es),
    .o_br             (o_br),
    .i_wb             (i_wb),
    .i_es_rd          (i_es_rd),
    .i_ms_rd          (i_ms_rd),
    .i_ws_rd          (i_ws_rd)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  // random back-pressure, hazards and write-back traffic
  task automatic jitter();
    if (rnd_on) begin
      i_es_allowin = ($urandom % 4) != 0;
      i_es_rd      = ($urandom % 3 == 0) ? 5'($urandom) : 5'd0;
      i_ms_rd      = ($urandom % 3 == 0) ? 5'($urandom) : 5'd0;
      i_ws_rd      = ($urandom % 3 == 0) ? 5'($urandom) : 5'd0;
      i_wb.wen     = ($urandom % 4) == 0;
      i_wb.waddr   = 5'($urandom);
      i_wb.wdata   = {$urandom, $urandom};
    end
  endtask

  task automatic tick();
    @(posedge i_clk);
    #1;
    jitter();
  endtask

  task automatic send(input logic [31:0] inst);
    int n;
    n = 0;
    i_fs_valid = 1'b1;
    i_fs.pc    = pc;
    i_fs.inst  = inst;
    #1; // let the combinational outputs settle
    while (!o_ds_allowin && n < max_wait) begin
      tick();
      #1;
      n++;
    end
    if (!o_ds_allowin) begin
      $display("timeout: decode stage never accepted instruction %h", inst);
      timeouts++;
    end
    tick();
    i_fs_valid = 1'b0;
    pc = pc + 64'd4;
  endtask

  task automatic drain();
    int n;
    n = 0;
    rnd_on = 1'b0;
    i_es_allowin = 1'b1;
    i_es_rd = 5'd0;
    i_ms_rd = 5'd0;
    i_ws_rd = 5'd0;
    i_wb.wen = 1'b0;
    #1;
    while (o_ds_to_es_valid && n < max_wait) begin
      tick();
      #1;
      n++;
    end
    if (o_ds_to_es_valid) begin
      $display("timeout: decode stage did not empty");
      timeouts++;
    end
    tick();
  endtask

  task automatic write_reg(input logic [4:0] idx, input logic [xlen-1:0] val);
    @(posedge i_clk);
    #1;
    i_wb = '{wen: 1'b1, waddr: idx, wdata: val};
  endtask

  initial begin
    logic [31:0] w;
    void'($urandom(32'hbfd8e6c6));
    kept = '{opc_op, opc_op_imm, opc_op_32, opc_op_imm_32, opc_lui, opc_auipc,
             opc_load, opc_store, opc_branch, opc_jal, opc_jalr};
    i_rst = 1'b1;
    i_fs_valid = 1'b0;
    i_fs = '0;
    i_es_allowin = 1'b1;
    i_wb = '0;
    i_es_rd = 5'd0;
    i_ms_rd = 5'd0;
    i_ws_rd = 5'd0;
    rnd_on = 1'b0;
    timeouts = 0;
    pc = 64'h0000_0000_8000_0000;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    for (int i = 0; i < 32; i++) begin
      write_reg(5'(i), {$urandom, $urandom}); // x0 write must be dropped
    end
    write_reg(5'd8, 64'h8000_0000_0000_0001);
    write_reg(5'd9, 64'h8000_0000_0000_0001);
    write_reg(5'd10, 64'd5);
    @(posedge i_clk);
    #1;
    i_wb.wen = 1'b0;

    // one of each format, every branch kind, jumps and bad encodings
    dir.push_back(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, opc_op));
    dir.push_back(enc(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, opc_op));
    dir.push_back(enc(7'h7f, 5'h1b, 5'd1, 3'd0, 5'd4, opc_op_imm));
    dir.push_back(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd5, opc_op_32));
    dir.push_back(enc(7'h20, 5'd5, 5'd1, 3'd5, 5'd6, opc_op_imm_32));
    dir.push_back(enc(7'h52, 5'h0a, 5'h0b, 3'd5, 5'd7, opc_lui));
    dir.push_back(enc(7'h05, 5'd0, 5'd0, 3'd0, 5'd11, opc_auipc));
    dir.push_back(enc(7'h00, 5'd8, 5'd2, 3'd3, 5'd12, opc_load));
    dir.push_back(enc(7'h7f, 5'd3, 5'd2, 3'd3, 5'h18, opc_store));
    dir.push_back(enc(7'h00, 5'd9, 5'd8, f3_beq, 5'h10, opc_branch));
    dir.push_back(enc(7'h00, 5'd9, 5'd8, f3_bne, 5'h10, opc_branch));
    dir.push_back(enc(7'h00, 5'd10, 5'd8, f3_blt, 5'h10, opc_branch));
    dir.push_back(enc(7'h00, 5'd10, 5'd8, f3_bge, 5'h10, opc_branch));
    dir.push_back(enc(7'h00, 5'd10, 5'd8, f3_bltu, 5'h10, opc_branch));
    dir.push_back(enc(7'h40, 5'd10, 5'd8, f3_bgeu, 5'h11, opc_branch));
    dir.push_back(enc(7'h00, 5'h08, 5'd0, 3'd0, 5'd1, opc_jal));
    dir.push_back(enc(7'h7f, 5'h1c, 5'd3, 3'd0, 5'd1, opc_jalr));
    dir.push_back(enc(7'h00, 5'd0, 5'd0, 3'd0, 5'd3, opc_op));
    dir.push_back(32'hffff_ffff);
    dir.push_back(enc(7'h01, 5'd2, 5'd1, 3'd0, 5'd3, opc_op));
    foreach (dir[k]) begin
      send(dir[k]);
    end

    // used rs2 against execute rd stalls, unused rs2 field does not
    send(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, opc_op));
    i_es_rd = 5'd2;
    repeat (3) tick();
    i_es_rd = 5'd0;
    send(enc(7'h00, 5'd2, 5'd1, 3'd0, 5'd4, opc_op_imm));
    i_ms_rd = 5'd2;
    i_es_allowin = 1'b0;
    repeat (2) tick();
    drain();

    rnd_on = 1'b1;
    for (int k = 0; k < 300; k++) begin
      w = $urandom;
      w[6:0] = ($urandom % 8 == 0) ? 7'($urandom) : kept[$urandom % 11];
      send(w);
    end
    drain();
    repeat (2) tick();

    $display("result: timeouts=%0d assertion failures=%0d", timeouts,
             dut_i.u_check.fail_cnt);
    if (timeouts == 0 && dut_i.u_check.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
logic/rv_isa_pkg.sv
logic/pipe_bus_pkg.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/branch_unit.sv
logic/id_stage.sv
tb/id_stage_assert.sv
tb/id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the decode stage testbench with Verilator, run it, grep the log for the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module id_stage_tb \
  -f files.f -o id_stage_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }
./obj_dir/id_stage_sim +verilator+error+limit+100000 > sim.log 2>&1
grep -qx "Simulation completed successfully" sim.log \
  && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
